/* bench/arm_front_testdata.txt */
# T start_pc flags(nzcv) | P first_addr count(decimal) words... | E pc word bits
# all values hex except count; bits are squashed, executed, taken in binary
T 00 0
P 00 7 e3a01001 e2812003 e5910000 e5810000 e3510000 ee000010 e3a00006
E 00 e3a01001 010  E 01 e2812003 010  E 02 e5910000 010
E 03 e5810000 010  E 04 e3510000 010  E 05 ee000010 010
T 10 0
P 10 7 e3a01001 ea000002 e2812003 e3510000 e5910000 e3a00015 e3a00016
E 10 e3a01001 010  E 11 ea000002 011  E 12 e320f000 100
E 14 e5910000 010  E 15 e3a00015 010
T 20 6
P 20 16 1a000010 0a000001 e3a00022 3a000010 2a000001 e3a00025 8a000010 9a000001
        e3a00028 ba000010 ca000010 da000001 e3a0002c fa000010 e3a0002e e3a0002f
E 20 1a000010 000  E 21 0a000001 011  E 22 e320f000 100
E 23 3a000010 000  E 24 2a000001 011  E 25 e320f000 100
E 26 8a000010 000  E 27 9a000001 011  E 28 e320f000 100
E 29 ba000010 000  E 2a ca000010 000  E 2b da000001 011
E 2c e320f000 100  E 2d fa000010 000  E 2e e3a0002e 010
T 30 0
P 30 6 e3a03003 7b000001 e3a00032 e2533001 1afffffe e3a00035
E 30 e3a03003 010  E 31 7b000001 011  E 32 e320f000 100
E 33 e2533001 010  E 34 1afffffe 011  E 35 e320f000 100
E 33 e2533001 010  E 34 1afffffe 011  E 35 e320f000 100
E 33 e2533001 010
T 02 9
P 02 7 e3812004 4a000000 6a000000 5a000005 aa000000 e2822001 e3a00008
E 02 e3812004 010  E 03 4a000000 011  E 04 e320f000 100
E 04 6a000000 011  E 05 e320f000 100  E 05 5a000005 000
E 06 aa000000 011  E 07 e320f000 100  E 07 e2822001 010

/* bench/tb_arm_front.sv */
`timescale 1ns/100ps

module tb_arm_front;
    import arm_front_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              imem_we;
    logic [pc_w-1:0]   imem_addr;
    logic [word_w-1:0] imem_data;
    logic              run;
    logic [pc_w-1:0]   start_pc;
    logic [3:0]        flags;
    logic              retire_valid;
    retire_t           retire;

    // records from the data file
    logic [pc_w-1:0]   test_pc [$];
    logic [3:0]        test_flags [$];
    logic [pc_w-1:0]   prog_addr [$];
    logic [word_w-1:0] prog_data [$];
    int                prog_test [$];
    logic [pc_w-1:0]   exp_pc [$];
    logic [word_w-1:0] exp_word [$];
    logic [2:0]        exp_bits [$];  // squashed, executed, taken
    int                exp_test [$];

    int error_count;
    int tests_failed;
    int watchdog_cycles;
    bit data_ok;

    arm_front_top i_arm_front_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .run          (run),
        .start_pc     (start_pc),
        .flags        (flags),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // opcode from the instruction class of the word
    function automatic opcode_e expected_opcode(input logic [word_w-1:0] word);
        opcode_e alu_ops [16];
        opcode_e op;
        // ARM data-processing opcode field order
        alu_ops = '{op_and, op_eor, op_sub, op_rsb, op_add, op_adc, op_sbc, op_rsc,
                    op_tst, op_teq, op_cmp, op_cmn, op_orr, op_mov, op_bic, op_mvn};
        op = op_undef;
        if (word == nop_word) begin
            op = op_nop;
        end else begin
            case (word[27:25])
                3'b000, 3'b001: op = alu_ops[word[24:21]];
                3'b010, 3'b011: op = word[20] ? op_ldr : op_str;  // L bit
                3'b101:         op = word[24] ? op_bl : op_b;      // link bit
                default:        op = op_undef;
            endcase
        end
        return op;
    endfunction

    task automatic read_testdata(output bit ok);
        int                fd;
        int                code;
        int                count;
        bit                more;
        logic [7:0]        kind;
        string             line;
        logic [pc_w-1:0]   addr;
        logic [3:0]        flag_v;
        logic [word_w-1:0] word;
        logic [2:0]        bits;

        ok = 1'b0;
        fd = $fopen("bench/arm_front_testdata.txt", "r");
        if (fd != 0) begin
            ok   = 1'b1;
            more = 1'b1;
            while (more) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    more = 1'b0;  // end of file
                end else begin
                    case (kind)
                        "#": code = $fgets(line, fd);
                        "T": begin
                            code = $fscanf(fd, " %h %h", addr, flag_v);
                            test_pc.push_back(addr);
                            test_flags.push_back(flag_v);
                        end
                        "P": begin
                            code = $fscanf(fd, " %h %d", addr, count);
                            for (int i = 0; i < count; i++) begin
                                code = $fscanf(fd, " %h", word);
                                prog_addr.push_back(addr + pc_w'(i));
                                prog_data.push_back(word);
                                prog_test.push_back(test_pc.size() - 1);
                            end
                        end
                        "E": begin
                            code = $fscanf(fd, " %h %h %b", addr, word, bits);
                            exp_pc.push_back(addr);
                            exp_word.push_back(word);
                            exp_bits.push_back(bits);
                            exp_test.push_back(test_pc.size() - 1);
                        end
                        default: begin
                            ok   = 1'b0;  // unknown record kind
                            more = 1'b0;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        if (test_pc.size() == 0) ok = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic compare_retire(input int t, input int i);
        string where;
        where = $sformatf("test %0d pc %02h", t, exp_pc[i]);
        check_value(32'(retire_valid), 32'd1, {where, " retire_valid"});
        check_value(32'(retire.pc), 32'(exp_pc[i]), {where, " pc"});
        check_value(retire.word, exp_word[i], {where, " word"});
        check_value(32'(retire.opcode), 32'(expected_opcode(exp_word[i])), {where, " opcode"});
        check_value(32'({retire.squashed, retire.executed, retire.taken}), 32'(exp_bits[i]),
                    {where, " squashed/executed/taken"});
    endtask

    task automatic run_test(input int t);
        int errors_before;
        int cycles;
        int retired;

        errors_before = error_count;
        for (int i = 0; i < prog_addr.size(); i++) begin
            if (prog_test[i] == t) begin
                @(negedge clk);
                imem_we   = 1'b1;
                imem_addr = prog_addr[i];
                imem_data = prog_data[i];
            end
        end
        @(negedge clk);
        imem_we  = 1'b0;
        start_pc = test_pc[t];
        flags    = test_flags[t];
        run      = 1'b1;
        cycles   = 0;
        while (!retire_valid && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        retired = 0;
        if (!retire_valid) begin
            $display("test %0d: nothing retired within 8 cycles of run going high", t);
            error_count++;
        end else begin
            check_value(32'(cycles), 32'd2, $sformatf("test %0d run to first retire", t));
            for (int i = 0; i < exp_pc.size(); i++) begin
                if (exp_test[i] == t) begin
                    if (retired > 0) @(negedge clk);  // one retire per cycle
                    compare_retire(t, i);
                    retired++;
                end
            end
        end
        run    = 1'b0;  // words in flight still retire
        cycles = 0;
        while (retire_valid && cycles < 6) begin
            @(negedge clk);
            cycles++;
        end
        if (retire_valid) begin
            $display("test %0d: retire_valid stayed high after run was dropped", t);
            error_count++;
        end
        if (error_count == errors_before) begin
            $display("test %0d: passed, %0d retires checked", t, retired);
        end else begin
            tests_failed++;
            $display("test %0d: failed with %0d errors", t, error_count - errors_before);
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        imem_we         = 1'b0;
        imem_addr       = '0;
        imem_data       = '0;
        run             = 1'b0;
        start_pc        = '0;
        flags           = '0;
        error_count     = 0;
        tests_failed    = 0;
        read_testdata(data_ok);
        if (data_ok) begin
            watchdog_cycles = exp_pc.size() + 20 * test_pc.size();
            apply_reset();
            for (int t = 0; t < test_pc.size(); t++) begin
                run_test(t);
            end
        end else begin
            $display("could not read bench/arm_front_testdata.txt or it holds no test");
            error_count++;
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors", test_pc.size(),
                 test_pc.size() - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // whole run limit from the trace lengths
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule : tb_arm_front

/* build.f */
logic/arm_front_pkg.sv
logic/instr_fetch.sv
logic/idecoder.sv
logic/memory_pipeline_unit.sv
logic/branch_resolver.sv
logic/arm_front_top.sv
bench/tb_arm_front.sv

/* logic/arm_front_pkg.sv */
package arm_front_pkg;

    // widths and sizes
    localparam int pc_w       = 7;
    localparam int word_w     = 32;
    localparam int imem_depth = 128;

    // cond al, MSR-style encoding with no effect, used as the bubble
    localparam logic [word_w-1:0] nop_word = 32'b1110_00110010_0000_11110000_00000000;

    // sixteen alu ops follow the ARM data-processing field order
    typedef enum logic [6:0] {
        op_and   = 7'd0,
        op_eor   = 7'd1,
        op_sub   = 7'd2,
        op_rsb   = 7'd3,
        op_add   = 7'd4,
        op_adc   = 7'd5,
        op_sbc   = 7'd6,
        op_rsc   = 7'd7,
        op_tst   = 7'd8,
        op_teq   = 7'd9,
        op_cmp   = 7'd10,
        op_cmn   = 7'd11,
        op_orr   = 7'd12,
        op_mov   = 7'd13,
        op_bic   = 7'd14,
        op_mvn   = 7'd15,
        op_ldr   = 7'd16,
        op_str   = 7'd17,
        op_b     = 7'd18,
        op_bl    = 7'd19,
        op_nop   = 7'd20,
        op_undef = 7'd21
    } opcode_e;

    // standard ARM condition field order
    typedef enum logic [3:0] {
        eq, ne, cs, cc, mi, pl, vs, vc,
        hi, ls, ge, lt, gt, le, al, nv
    } cond_e;

    // fetch to decode stage
    typedef struct packed {
        logic              valid;
        logic              epoch;  // branch epoch at fetch time
        logic [pc_w-1:0]   pc;
        logic [word_w-1:0] word;
    } fetch_item_t;

    // decode stage to branch resolver
    typedef struct packed {
        logic              valid;
        logic              squashed;    // word replaced by nop_word
        logic [pc_w-1:0]   pc;
        logic [word_w-1:0] word;
        cond_e             cond;
        opcode_e           opcode;
        logic              en_status;
        logic [3:0]        rn;
        logic [3:0]        rd;
        logic [1:0]        shift_op;
        logic [11:0]       imm12;
        logic [word_w-1:0] imm_branch;  // sign extended word offset
        logic              p;
        logic              u;
        logic              w;
    } decoded_t;

    // resolver back to fetch
    typedef struct packed {
        logic            taken;
        logic [pc_w-1:0] target;
    } redirect_t;

    // one entry per retired word
    typedef struct packed {
        logic [pc_w-1:0]   pc;
        logic [word_w-1:0] word;
        opcode_e           opcode;
        logic              squashed;
        logic              executed;  // condition passed, not squashed
        logic              taken;
    } retire_t;

endpackage : arm_front_pkg

/* logic/arm_front_top.sv */
`timescale 1ns/100ps

module arm_front_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             imem_we,
    input  logic [arm_front_pkg::pc_w-1:0]   imem_addr,
    input  logic [arm_front_pkg::word_w-1:0] imem_data,
    input  logic                             run,
    input  logic [arm_front_pkg::pc_w-1:0]   start_pc,
    input  logic [3:0]                       flags,
    output logic                             retire_valid,
    output arm_front_pkg::retire_t           retire
);
    import arm_front_pkg::*;

    fetch_item_t item;
    decoded_t    dec;
    redirect_t   redirect;
    logic        branch_ref;

    instr_fetch i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .run       (run),
        .start_pc  (start_pc),
        .redirect  (redirect),
        .item      (item)
    );

    memory_pipeline_unit i_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .item       (item),
        .branch_ref (branch_ref),
        .dec        (dec)
    );

    branch_resolver i_resolve (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .flags        (flags),
        .redirect     (redirect),   // back to fetch, same cycle
        .branch_ref   (branch_ref),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule : arm_front_top

/* logic/branch_resolver.sv */
`timescale 1ns/100ps

module branch_resolver (
    input  logic                    clk,
    input  logic                    rst_n,
    input  arm_front_pkg::decoded_t dec,
    input  logic [3:0]              flags,     // nzcv
    output arm_front_pkg::redirect_t redirect,
    output logic                    branch_ref,
    output logic                    retire_valid,
    output arm_front_pkg::retire_t  retire
);
    import arm_front_pkg::*;

    logic n;
    logic z;
    logic c;
    logic v;
    logic cond_pass;
    logic is_branch;
    logic taken;

    assign n = flags[3];
    assign z = flags[2];
    assign c = flags[1];
    assign v = flags[0];

    // ARM condition table
    always_comb begin
        case (dec.cond)
            eq:      cond_pass = z;
            ne:      cond_pass = !z;
            cs:      cond_pass = c;
            cc:      cond_pass = !c;
            mi:      cond_pass = n;
            pl:      cond_pass = !n;
            vs:      cond_pass = v;
            vc:      cond_pass = !v;
            hi:      cond_pass = c && !z;
            ls:      cond_pass = !c || z;
            ge:      cond_pass = (n == v);
            lt:      cond_pass = (n != v);
            gt:      cond_pass = !z && (n == v);
            le:      cond_pass = z || (n != v);
            al:      cond_pass = 1'b1;
            default: cond_pass = 1'b0;  // nv never
        endcase
    end

    assign is_branch = dec.valid && !dec.squashed &&
                       ((dec.opcode == op_b) || (dec.opcode == op_bl));
    assign taken     = is_branch && cond_pass;

    // target relative to the word after the branch
    assign redirect.taken  = taken;
    assign redirect.target = dec.pc + 1'b1 + dec.imm_branch[pc_w-1:0];

    // epoch owner, flips at the end of a taken branch cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_ref <= 1'b0;
        end else if (taken) begin
            branch_ref <= !branch_ref;
        end
    end

    assign retire_valid = dec.valid;
    assign retire = '{pc: dec.pc, word: dec.word, opcode: dec.opcode,
                      squashed: dec.squashed,
                      executed: cond_pass && !dec.squashed,
                      taken: taken};

endmodule : branch_resolver

/* logic/idecoder.sv */
`timescale 1ns/100ps

module idecoder (
    input  logic [arm_front_pkg::word_w-1:0] instr,
    output arm_front_pkg::cond_e             cond,
    output arm_front_pkg::opcode_e           opcode,
    output logic                             en_status,
    output logic [3:0]                       rn,
    output logic [3:0]                       rd,
    output logic [3:0]                       rs,
    output logic [3:0]                       rm,
    output logic [1:0]                       shift_op,
    output logic [4:0]                       imm5,
    output logic [11:0]                      imm12,
    output logic [arm_front_pkg::word_w-1:0] imm_branch,
    output logic                             p,
    output logic                             u,
    output logic                             w
);
    import arm_front_pkg::*;

    logic is_nop;
    logic is_dp;   // data processing
    logic is_ls;   // single load/store
    logic is_br;   // b or bl

    // instruction class from bits 27:25
    assign is_nop = (instr == nop_word);
    assign is_dp  = !is_nop && (instr[27:26] == 2'b00);
    assign is_ls  = !is_nop && (instr[27:26] == 2'b01);
    assign is_br  = !is_nop && (instr[27:25] == 3'b101);

    assign cond = cond_e'(instr[31:28]);

    always_comb begin
        opcode = op_undef;  // anything unmatched
        if (is_nop) begin
            opcode = op_nop;
        end else if (is_dp) begin
            opcode = opcode_e'({3'b000, instr[24:21]});
        end else if (is_ls) begin
            opcode = instr[20] ? op_ldr : op_str;  // L bit
        end else if (is_br) begin
            opcode = instr[24] ? op_bl : op_b;     // link bit
        end
    end

    // S bit only means something on alu ops
    assign en_status = is_dp & instr[20];

    // register fields
    assign rn = instr[19:16];
    assign rd = instr[15:12];
    assign rs = instr[11:8];
    assign rm = instr[3:0];

    // shifter operand
    assign shift_op = instr[6:5];
    assign imm5     = instr[11:7];
    assign imm12    = instr[11:0];

    // word offset, already in words since pc counts words
    assign imm_branch = {{8{instr[23]}}, instr[23:0]};

    // indexing bits of load/store, zero for other classes
    always_comb begin
        p = 1'b0;
        u = 1'b0;
        w = 1'b0;
        if (is_ls) begin
            p = instr[24];
            u = instr[23];
            w = instr[21];
        end
    end

endmodule : idecoder

/* logic/instr_fetch.sv */
`timescale 1ns/100ps

module instr_fetch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             imem_we,
    input  logic [arm_front_pkg::pc_w-1:0]   imem_addr,
    input  logic [arm_front_pkg::word_w-1:0] imem_data,
    input  logic                             run,
    input  logic [arm_front_pkg::pc_w-1:0]   start_pc,
    input  arm_front_pkg::redirect_t         redirect,
    output arm_front_pkg::fetch_item_t       item
);
    import arm_front_pkg::*;

    logic [word_w-1:0] imem [imem_depth];

    logic              run_q;
    logic              start;
    logic [pc_w-1:0]   pc_q;       // next pc to fetch
    logic [pc_w-1:0]   fetch_pc;
    logic              epoch_q;
    logic              next_epoch;
    logic              item_valid;
    logic [pc_w-1:0]   item_pc;
    logic [word_w-1:0] item_word;

    assign start = run & ~run_q;  // first edge with run high

    // epoch follows every redirect, also while stopped,
    // so it never drifts from the resolver's copy
    assign next_epoch = epoch_q ^ redirect.taken;

    always_comb begin
        if (start) begin
            fetch_pc = start_pc;
        end else if (redirect.taken) begin
            fetch_pc = redirect.target;
        end else begin
            fetch_pc = pc_q;
        end
    end

    // load port, only while stopped
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q      <= 1'b0;
            pc_q       <= '0;
            epoch_q    <= 1'b0;
            item_valid <= 1'b0;
        end else begin
            run_q      <= run;
            epoch_q    <= next_epoch;
            item_valid <= run;  // invalid items while stopped
            if (run) begin
                pc_q <= fetch_pc + 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (run) begin
            item_pc   <= fetch_pc;
            item_word <= imem[fetch_pc];
        end
    end

    // item epoch is the epoch in force after the edge
    assign item = '{valid: item_valid, epoch: epoch_q, pc: item_pc, word: item_word};

endmodule : instr_fetch

/* logic/memory_pipeline_unit.sv */
`timescale 1ns/100ps

module memory_pipeline_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  arm_front_pkg::fetch_item_t item,
    input  logic                       branch_ref,
    output arm_front_pkg::decoded_t    dec
);
    import arm_front_pkg::*;

    logic [word_w-1:0] instr_reg;
    logic              epoch_reg;
    logic [pc_w-1:0]   pc_reg;
    logic              valid_reg;
    logic              squash;
    logic [word_w-1:0] instr_dec;

    cond_e             cond;
    opcode_e           opcode;
    logic              en_status;
    logic [3:0]        rn;
    logic [3:0]        rd;
    logic [1:0]        shift_op;
    logic [11:0]       imm12;
    logic [word_w-1:0] imm_branch;
    logic              p;
    logic              u;
    logic              w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_reg <= nop_word;
            epoch_reg <= 1'b0;
            pc_reg    <= '0;
            valid_reg <= 1'b0;
        end else begin
            instr_reg <= item.word;
            epoch_reg <= item.epoch;
            pc_reg    <= item.pc;
            valid_reg <= item.valid;
        end
    end

    // stale epoch means fetched down the wrong path
    assign squash    = (epoch_reg != branch_ref);
    assign instr_dec = squash ? nop_word : instr_reg;

    idecoder decoder (
        .instr      (instr_dec),
        .cond       (cond),
        .opcode     (opcode),
        .en_status  (en_status),
        .rn         (rn),
        .rd         (rd),
        .rs         (),
        .rm         (),
        .shift_op   (shift_op),
        .imm5       (),
        .imm12      (imm12),
        .imm_branch (imm_branch),
        .p          (p),
        .u          (u),
        .w          (w)
    );

    assign dec = '{valid: valid_reg, squashed: squash, pc: pc_reg, word: instr_dec,
                   cond: cond, opcode: opcode, en_status: en_status, rn: rn, rd: rd,
                   shift_op: shift_op, imm12: imm12, imm_branch: imm_branch,
                   p: p, u: u, w: w};

endmodule : memory_pipeline_unit

/* run_sim.sh */
#!/usr/bin/env bash
# build and run tb_arm_front with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_arm_front \
        -f build.f -o tb_arm_front_sim \
    && ./obj_dir/tb_arm_front_sim | tee /dev/stderr | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
